// File: common/icache_pkg.sv
/* Instruction cache shared types */

`default_nettype none

package icache_pkg;

    // Address and data geometry
    localparam int ADDR_BITS   = 32;
    localparam int WORD_BITS   = 32;
    localparam int BLOCK_BITS  = 128;
    localparam int OFFSET_BITS = 4;
    localparam int BEATS       = 4;

    // Fixed two-way associativity
    localparam int WAYS = 2;

    typedef logic [BLOCK_BITS-1:0] block_t;

    // Fetch request from the core
    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] addr;
    } fetch_req_t;

    // Instruction word back to the core
    typedef struct packed {
        logic                 valid;
        logic [WORD_BITS-1:0] data;
    } fetch_rsp_t;

    // One word from the memory port
    typedef struct packed {
        logic                 valid;
        logic [WORD_BITS-1:0] data;
    } mem_beat_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: icache/icache_array.sv
/* Two-way set-associative cache array */

`timescale 1ns/1ps
`default_nettype none

module icache_array import icache_pkg::*; #(
    parameter int NUM_SETS = 32
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              en,
    input  wire logic                              fill,
    input  wire logic [ADDR_BITS-OFFSET_BITS-1:0]  block_addr,
    input  wire block_t                            fill_data,
    output logic                                   hit,
    output block_t                                 block
);

    localparam int IDX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - IDX_BITS;

    // Storage columns
    logic [WAYS-1:0]     valid_col  [NUM_SETS];
    logic [WAYS-1:0]     status_col [NUM_SETS];
    logic [TAG_BITS-1:0] tag_col    [NUM_SETS][WAYS];
    block_t              data_col   [NUM_SETS][WAYS];

    logic [IDX_BITS-1:0] index;
    logic [TAG_BITS-1:0] tag;
    logic [WAYS-1:0]     way_hit;
    logic [WAYS-1:0]     victim;
    logic [WAYS-1:0]     touch;
    logic [WAYS-1:0]     status_next;
    logic                found;

    assign index = block_addr[IDX_BITS-1:0];
    assign tag   = block_addr[TAG_BITS+IDX_BITS-1:IDX_BITS];

    // Tag compare and block read
    always_comb begin
        block = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = en && valid_col[index][w] && (tag_col[index][w] == tag);
            if (way_hit[w]) begin
                block = block | data_col[index][w];
            end
        end
    end

    assign hit = |way_hit;

    // Victim is the lowest way with a clear status bit
    always_comb begin
        victim = '0;
        found  = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (!status_col[index][w] && !found) begin
                victim[w] = 1'b1;
                found     = 1'b1;
            end
        end
    end

    // PLRU: mark the touched way, keep only it if all ways end up marked
    always_comb begin
        touch       = hit ? way_hit : victim;
        status_next = status_col[index] | touch;
        if (&status_next) begin
            status_next = touch;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_col[s]  <= '0;
                status_col[s] <= '0;
            end
        end else if (en) begin
            if (hit) begin
                status_col[index] <= status_next;
            end else if (fill) begin
                valid_col[index]  <= valid_col[index] | victim;
                status_col[index] <= status_next;
            end
        end
    end

    // Tag and data for the refilled way
    always_ff @(posedge clk) begin
        if (en && fill && !hit) begin
            for (int w = 0; w < WAYS; w++) begin
                if (victim[w]) begin
                    tag_col[index][w]  <= tag;
                    data_col[index][w] <= fill_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_ctrl.sv
/* Instruction fetch controller */

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; #(
    parameter int NUM_SETS = 32
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire fetch_req_t  req,
    output fetch_rsp_t       rsp,
    output logic             ready,
    output logic             lookup_en,
    output logic [ADDR_BITS-OFFSET_BITS-1:0] lookup_addr,
    input  wire logic        hit,
    input  wire block_t      block,
    output logic             refill_start,
    input  wire logic        refill_done
);

    localparam int IDX_BITS      = $clog2(NUM_SETS);
    localparam int TAG_BITS      = ADDR_BITS - OFFSET_BITS - IDX_BITS;
    localparam int WORD_SEL_BITS = OFFSET_BITS - 2;

    ctrl_state_e              state;
    logic [ADDR_BITS-1:0]     addr_q;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic                     rsp_valid;
    logic [WORD_BITS-1:0]     rsp_word;

    assign ready    = (state == ST_IDLE);
    assign word_sel = addr_q[OFFSET_BITS-1:2];

    // Tag and index of the latched fetch
    assign lookup_addr = addr_q[TAG_BITS+IDX_BITS+OFFSET_BITS-1:OFFSET_BITS];

    // Array stays enabled on the fill cycle so the victim gets written
    assign lookup_en = (state == ST_LOOKUP) || (state == ST_REFILL && refill_done);

    assign refill_start = (state == ST_LOOKUP) && !hit;

    assign rsp = '{valid: rsp_valid, data: rsp_word};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= ST_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req.valid) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        rsp_valid <= 1'b1;
                        state     <= ST_IDLE;
                    end else begin
                        state <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (refill_done) begin
                        state <= ST_LOOKUP;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Fetch address and returned word
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req.valid) begin
            addr_q <= req.addr;
        end
        if (state == ST_LOOKUP && hit) begin
            rsp_word <= block[word_sel*WORD_BITS +: WORD_BITS];
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_refill.sv
/* Block refill collector */

`timescale 1ns/1ps
`default_nettype none

module icache_refill import icache_pkg::*; (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              start,
    input  wire logic [ADDR_BITS-OFFSET_BITS-1:0]  block_addr,
    output logic                                   mem_req,
    output logic [ADDR_BITS-1:0]                   mem_addr,
    input  wire mem_beat_t                         mem_beat,
    output logic                                   fill,
    output block_t                                 fill_data
);

    localparam int CNT_BITS = $clog2(BEATS);

    logic [ADDR_BITS-OFFSET_BITS-1:0] base_q;
    logic [CNT_BITS-1:0]              beat_cnt;
    logic                             last_beat;

    // Block-aligned byte address
    assign mem_addr  = {base_q, {OFFSET_BITS{1'b0}}};
    assign last_beat = mem_beat.valid && (beat_cnt == CNT_BITS'(BEATS - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_req  <= 1'b0;
            fill     <= 1'b0;
            beat_cnt <= '0;
        end else begin
            mem_req <= start;
            fill    <= last_beat;
            if (start) begin
                beat_cnt <= '0;
            end else if (mem_beat.valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base_q <= block_addr;
        end
        // First beat ends up in the low word after four shifts
        if (mem_beat.valid) begin
            fill_data <= {mem_beat.data, fill_data[BLOCK_BITS-1:WORD_BITS]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
/* Instruction cache top level */

`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int NUM_SETS = 32
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire fetch_req_t      req,
    output fetch_rsp_t           rsp,
    output logic                 ready,
    output logic                 mem_req,
    output logic [ADDR_BITS-1:0] mem_addr,
    input  wire mem_beat_t       mem_beat
);

    logic                             lookup_en;
    logic [ADDR_BITS-OFFSET_BITS-1:0] lookup_addr;
    logic                             hit;
    block_t                           block;
    logic                             refill_start;
    logic                             fill;
    block_t                           fill_data;

    icache_ctrl #(
        .NUM_SETS(NUM_SETS)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .rsp         (rsp),
        .ready       (ready),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .block       (block),
        .refill_start(refill_start),
        .refill_done (fill)
    );

    icache_array #(
        .NUM_SETS(NUM_SETS)
    ) u_array (
        .clk       (clk),
        .rst       (rst),
        .en        (lookup_en),
        .fill      (fill),
        .block_addr(lookup_addr),
        .fill_data (fill_data),
        .hit       (hit),
        .block     (block)
    );

    // Refill uses the address the controller is looking up
    icache_refill u_refill (
        .clk       (clk),
        .rst       (rst),
        .start     (refill_start),
        .block_addr(lookup_addr),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_beat  (mem_beat),
        .fill      (fill),
        .fill_data (fill_data)
    );

endmodule

`default_nettype wire

// File: verification/mem_model.sv
/* Refill memory responder */

`timescale 1ns/1ps
`default_nettype none

module mem_model import icache_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 mem_req,
    input  wire logic [ADDR_BITS-1:0] mem_addr,
    input  wire logic [1:0]           gap,
    output mem_beat_t                 mem_beat,
    output int unsigned               req_count
);

    logic [ADDR_BITS-1:0] addr_q;
    logic [1:0]           beat_idx;
    logic [1:0]           wait_cnt;
    logic                 busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_beat  <= '0;
            req_count <= 0;
            addr_q    <= '0;
            beat_idx  <= '0;
            wait_cnt  <= '0;
            busy      <= 1'b0;
        end else begin
            mem_beat.valid <= 1'b0;
            if (mem_req) begin
                busy      <= 1'b1;
                addr_q    <= mem_addr;
                beat_idx  <= '0;
                wait_cnt  <= gap;
                req_count <= req_count + 1;
            end else if (busy) begin
                if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    // Word content is the inverted byte address
                    mem_beat <= '{valid: 1'b1, data: ~(addr_q + {28'b0, beat_idx, 2'b00})};
                    wait_cnt <= gap;
                    beat_idx <= beat_idx + 2'd1;
                    if (beat_idx == 2'(BEATS - 1)) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/icache_tb.sv
/* Instruction cache testbench */

`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ;

    localparam int NUM_SETS   = 32;
    localparam int IDX_BITS   = 5;
    localparam int TAG_BITS   = 23;
    localparam int HIT_CYCLES = 1;
    localparam int TIMEOUT    = 200;

    logic        clk;
    logic        rst;
    fetch_req_t  req;
    fetch_rsp_t  rsp;
    logic        ready;
    logic        mem_req;
    logic [31:0] mem_addr;
    mem_beat_t   mem_beat;
    logic [1:0]  gap;
    int unsigned req_count;
    logic [31:0] gap_state;
    logic [31:0] addr_state;

    // Reference model of tags, valid and PLRU status
    logic [TAG_BITS-1:0] ref_tag    [NUM_SETS][2];
    logic [1:0]          ref_valid  [NUM_SETS];
    logic [1:0]          ref_status [NUM_SETS];

    icache_top #(
        .NUM_SETS(NUM_SETS)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .rsp     (rsp),
        .ready   (ready),
        .mem_req (mem_req),
        .mem_addr(mem_addr),
        .mem_beat(mem_beat)
    );

    mem_model u_mem (
        .clk      (clk),
        .rst      (rst),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .gap      (gap),
        .mem_beat (mem_beat),
        .req_count(req_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random idle cycles for the memory
    always @(posedge clk) begin
        gap_state = lcg_step(gap_state);
        gap <= gap_state[17:16];
    end

    function automatic logic [31:0] make_addr(input logic [TAG_BITS-1:0] tag,
                                              input logic [IDX_BITS-1:0] idx,
                                              input logic [1:0] word);
        return {tag, idx, word, 2'b00};
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic ref_clear();
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[s]  = 2'b00;
            ref_status[s] = 2'b00;
        end
    endtask

    // Predicts a miss and updates tags and status
    task automatic ref_access(input logic [31:0] addr, output logic miss);
        logic [IDX_BITS-1:0] s;
        logic [TAG_BITS-1:0] t;
        logic                hit0;
        logic                hit1;
        logic                way;
        logic [1:0]          touch;
        s    = addr[8:4];
        t    = addr[31:9];
        hit0 = ref_valid[s][0] && (ref_tag[s][0] == t);
        hit1 = ref_valid[s][1] && (ref_tag[s][1] == t);
        miss = !(hit0 || hit1);
        // Victim is way 0 unless its bit is set
        way  = miss ? ref_status[s][0] : hit1;
        if (miss) begin
            ref_valid[s][way] = 1'b1;
            ref_tag[s][way]   = t;
        end
        touch = way ? 2'b10 : 2'b01;
        ref_status[s] = ref_status[s] | touch;
        if (&ref_status[s]) begin
            ref_status[s] = touch;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        ref_clear();
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: ready never returned high");
                abort_run();
            end
        end
    endtask

    // One fetch with data, latency and request count checks
    task automatic fetch(input logic [31:0] addr, output logic miss, output int cycles);
        int unsigned reqs_before;
        ref_access(addr, miss);
        wait_ready();
        reqs_before = req_count;
        @(posedge clk);
        req <= '{valid: 1'b1, addr: addr};
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        check(32'(ready), 32'd0, "ready low after accept");
        cycles = 0;
        while (!rsp.valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: no response for fetch of %h", addr);
                abort_run();
            end
        end
        check(rsp.data, ~{addr[31:2], 2'b00}, "fetched word");
        check(32'(ready), 32'd1, "ready with response");
        check(req_count - reqs_before, miss ? 32'd1 : 32'd0, "memory requests");
        @(negedge clk);
        check(32'(rsp.valid), 32'd0, "response lasts one cycle");
    endtask

    task automatic test_cold_miss();
        logic miss;
        int   cycles;
        for (int w = 0; w < 4; w++) begin
            fetch(make_addr(23'd5, 5'd1, 2'(w)), miss, cycles);
            check(32'(miss), (w == 0) ? 32'd1 : 32'd0, "cold block miss pattern");
        end
        fetch(make_addr(23'd5, 5'd1, 2'd2), miss, cycles);
        check(32'(miss), 32'd0, "repeat fetch hits");
        check(cycles, HIT_CYCLES, "hit latency");
    endtask

    task automatic test_two_ways();
        logic miss;
        int   cycles;
        fetch(make_addr(23'd7, 5'd2, 2'd0), miss, cycles);
        check(32'(miss), 32'd1, "first tag misses");
        fetch(make_addr(23'd9, 5'd2, 2'd1), miss, cycles);
        check(32'(miss), 32'd1, "second tag misses");
        for (int i = 0; i < 6; i++) begin
            fetch(make_addr(i[0] ? 23'd9 : 23'd7, 5'd2, 2'(i)), miss, cycles);
            check(32'(miss), 32'd0, "both ways resident");
        end
    endtask

    task automatic test_plru_evict();
        logic [TAG_BITS-1:0] order [6];
        logic                exp   [6];
        logic                miss;
        int                  cycles;
        // A, B, A, C, then A hits and B was evicted
        order = '{23'd1, 23'd2, 23'd1, 23'd3, 23'd1, 23'd2};
        exp   = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
        for (int i = 0; i < 6; i++) begin
            fetch(make_addr(order[i], 5'd3, 2'd0), miss, cycles);
            check(32'(miss), 32'(exp[i]), "PLRU access sequence");
        end
    endtask

    task automatic test_reset_clears();
        logic miss;
        int   cycles;
        // Reset lands while a miss is in progress
        wait_ready();
        @(posedge clk);
        req <= '{valid: 1'b1, addr: make_addr(23'd11, 5'd4, 2'd0)};
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        check(32'(ready), 32'd0, "busy before reset");
        apply_reset();
        @(negedge clk);
        check(32'(ready), 32'd1, "ready after reset");
        check(32'(rsp.valid), 32'd0, "no response after reset");
        fetch(make_addr(23'd5, 5'd1, 2'd2), miss, cycles);
        check(32'(miss), 32'd1, "old block gone after reset");
    endtask

    task automatic test_random_stream();
        logic        miss;
        int          cycles;
        int unsigned misses;
        int unsigned reqs_start;
        logic [31:0] addr;
        misses     = 0;
        reqs_start = req_count;
        for (int i = 0; i < 200; i++) begin
            addr_state = lcg_step(addr_state);
            addr = make_addr(23'(addr_state[18:16]), {3'b011, addr_state[21:20]},
                             addr_state[25:24]);
            fetch(addr, miss, cycles);
            if (miss) begin
                misses++;
            end
        end
        check(req_count - reqs_start, misses, "total requests in random stream");
    endtask

    initial begin
        rst        = 1'b0;
        req        = '0;
        gap        = 2'd0;
        gap_state  = 32'hbcfb_6df1;
        addr_state = lcg_step(32'hbcfb_6df1);
        apply_reset();
        test_cold_miss();
        test_two_ways();
        test_plru_evict();
        test_reset_clears();
        test_random_stream();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
common/icache_pkg.sv
icache/icache_array.sv
icache/icache_ctrl.sv
icache/icache_refill.sv
verilog/icache_top.sv
verification/mem_model.sv
verification/icache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module icache_tb -f flist.f -o icache_sim
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
